// File: hw/dec_cfg.svh
// Sizing macros for the decode stage, included by every package and module that needs a width
`ifndef DEC_CFG_SVH
`define DEC_CFG_SVH

// ***********************************************************
// datapath
// ***********************************************************
`define DEC_XLEN 32  // data and pc width

// ***********************************************************
// storage
// ***********************************************************
`define DEC_IB_DEPTH 2  // instruction buffer entries

`define DEC_NUM_GPR 32  // integer registers, x0 included

`define DEC_REG_AW 5  // register address width

`endif

// File: hw/dec_isa_pkg.sv
// RV32I encodings used by decode; import wherever opcodes, ALU ops or instruction views are needed
package dec_isa_pkg;

  // ***********************************************************
  // major opcodes, low bits 11 included
  // ***********************************************************
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_auipc  = 7'b0010111,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    f3_add_sub = 3'b000,  // addi too
    f3_sll     = 3'b001,
    f3_slt     = 3'b010,
    f3_sltu    = 3'b011,
    f3_xor     = 3'b100,
    f3_srl_sra = 3'b101,
    f3_or      = 3'b110,
    f3_and     = 3'b111
  } funct3_alu_e;

  typedef enum logic [2:0] {
    f3_beq  = 3'b000,
    f3_bne  = 3'b001,
    f3_blt  = 3'b100,
    f3_bge  = 3'b101,
    f3_bltu = 3'b110,
    f3_bgeu = 3'b111
  } funct3_br_e;

  typedef enum logic [2:0] {
    f3_byte  = 3'b000,
    f3_half  = 3'b001,
    f3_word  = 3'b010,
    f3_byteu = 3'b100,  // loads only
    f3_halfu = 3'b101   // loads only
  } funct3_mem_e;

  typedef enum logic [6:0] {
    f7_base = 7'b0000000,
    f7_alt  = 7'b0100000  // sub, sra, srai
  } funct7_e;

  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_lui, alu_auipc, alu_jal, alu_jalr,
    alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu,
    alu_load, alu_store
  } alu_op_e;

  typedef enum logic [2:0] {
    imm_none, imm_i, imm_s, imm_b, imm_u, imm_j
  } imm_fmt_e;

  // ***********************************************************
  // instruction word views, msb first
  // ***********************************************************
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

endpackage

// File: hw/dec_pipe_pkg.sv
// Packets passed between fetch, decode, the register file and execute; import where a port uses one
`include "dec_cfg.svh"

package dec_pipe_pkg;

  // ***********************************************************
  // fetch side
  // ***********************************************************
  typedef struct packed {
    logic                 valid;  // fetch offers a word
    logic [`DEC_XLEN-1:0] instr;  // raw 32b word
    logic [`DEC_XLEN-1:0] pc;
  } fetch_pkt_t;

  // ***********************************************************
  // register file ports
  // ***********************************************************
  typedef struct packed {
    logic                   wen;
    logic [`DEC_REG_AW-1:0] waddr;  // x0 writes dropped
    logic [`DEC_XLEN-1:0]   wdata;
  } wb_pkt_t;

  typedef struct packed {
    logic [`DEC_REG_AW-1:0] rs1_addr;
    logic [`DEC_REG_AW-1:0] rs2_addr;
    logic                   rs1_en;  // off gives zero data
    logic                   rs2_en;
  } gpr_rd_t;

  // ***********************************************************
  // decode to execute
  // ***********************************************************
  typedef struct packed {
    logic                   valid;
    logic                   illegal;   // bad encoding, no writeback
    dec_isa_pkg::alu_op_e   op;
    logic [`DEC_REG_AW-1:0] rd;        // zero when rd_wen low
    logic                   rd_wen;
    logic [`DEC_XLEN-1:0]   rs1_data;
    logic [`DEC_XLEN-1:0]   rs2_data;
    logic [`DEC_XLEN-1:0]   immed;     // sign extended
    logic [`DEC_XLEN-1:0]   pc;
  } alu_pkt_t;

endpackage

// File: hw/dec_ib.sv
// Two-entry instruction buffer between fetch and decode; instantiated once in the decode top level
`timescale 1ns/100ps
`include "dec_cfg.svh"

module dec_ib (
  input  logic                     clk,
  input  logic                     reset,
  input  dec_pipe_pkg::fetch_pkt_t fetch,
  output logic                     ib_ready,
  input  logic                     ib_pop,
  output dec_pipe_pkg::fetch_pkt_t ib_head
);

  localparam int ptr_w = $clog2(`DEC_IB_DEPTH);
  localparam int cnt_w = $clog2(`DEC_IB_DEPTH + 1);

  logic [`DEC_XLEN-1:0] instr_q [`DEC_IB_DEPTH];  // payload, no reset
  logic [`DEC_XLEN-1:0] pc_q    [`DEC_IB_DEPTH];
  logic [ptr_w-1:0]     wr_ptr_q;
  logic [ptr_w-1:0]     rd_ptr_q;
  logic [cnt_w-1:0]     count_q;
  logic                 empty;
  logic                 push;
  logic                 pop;

  assign empty    = (count_q == '0);
  assign pop      = ib_pop & ~empty;
  // full buffer still takes a word when the head leaves this cycle
  assign ib_ready = (count_q < cnt_w'(`DEC_IB_DEPTH)) | pop;
  assign push     = fetch.valid & ib_ready;

  // ***********************************************************
  // storage
  // ***********************************************************
  always_ff @(posedge clk) begin
    if (push) begin
      instr_q[wr_ptr_q] <= fetch.instr;
      pc_q[wr_ptr_q]    <= fetch.pc;
    end
  end

  // ***********************************************************
  // pointers and occupancy
  // ***********************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(`DEC_IB_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;  // wrap
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(`DEC_IB_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

  assign ib_head.valid = ~empty;  // head is oldest entry
  assign ib_head.instr = instr_q[rd_ptr_q];
  assign ib_head.pc    = pc_q[rd_ptr_q];

endmodule

// File: hw/dec_decode_ctl.sv
// Decode control for the head instruction; owns the packet register toward execute and the stall
`timescale 1ns/100ps
`include "dec_cfg.svh"

module dec_decode_ctl (
  input  logic                     clk,
  input  logic                     reset,
  input  dec_pipe_pkg::fetch_pkt_t ib_head,
  output logic                     ib_pop,
  output dec_pipe_pkg::gpr_rd_t    gpr_rd,
  input  logic [`DEC_XLEN-1:0]     rs1_data,
  input  logic [`DEC_XLEN-1:0]     rs2_data,
  output dec_isa_pkg::instr_u      head_instr,
  output dec_isa_pkg::imm_fmt_e    imm_fmt,
  input  logic [`DEC_XLEN-1:0]     immed,
  input  logic                     exu_stall,
  output dec_pipe_pkg::alu_pkt_t   dec_pkt
);

  import dec_isa_pkg::*;
  import dec_pipe_pkg::*;

  instr_u   word;         // head seen through the format views
  alu_op_e  op_dec;
  imm_fmt_e fmt_dec;
  logic     rs1_en_dec;
  logic     rs2_en_dec;
  logic     rd_wen_dec;
  logic     legal_dec;    // opcode and funct fields valid
  logic     illegal;
  logic     f7_base_hit;
  logic     f7_alt_hit;
  logic     load;         // packet register takes the head
  alu_pkt_t next_pkt;

  assign word        = ib_head.instr;
  assign head_instr  = word;
  assign f7_base_hit = (word.r.funct7 == f7_base);
  assign f7_alt_hit  = (word.r.funct7 == f7_alt);

  // ***********************************************************
  // opcode and funct decode
  // ***********************************************************
  always_comb begin
    op_dec     = alu_add;
    fmt_dec    = imm_none;
    rs1_en_dec = 1'b0;
    rs2_en_dec = 1'b0;
    rd_wen_dec = 1'b0;
    legal_dec  = 1'b1;
    case (word.r.opcode)
      opc_lui: begin
        op_dec     = alu_lui;
        fmt_dec    = imm_u;
        rd_wen_dec = 1'b1;
      end
      opc_auipc: begin
        op_dec     = alu_auipc;
        fmt_dec    = imm_u;
        rd_wen_dec = 1'b1;
      end
      opc_jal: begin
        op_dec     = alu_jal;
        fmt_dec    = imm_j;
        rd_wen_dec = 1'b1;
      end
      opc_jalr: begin
        op_dec     = alu_jalr;
        fmt_dec    = imm_i;
        rs1_en_dec = 1'b1;
        rd_wen_dec = 1'b1;
        legal_dec  = (word.i.funct3 == 3'b000);  // only funct3 0
      end
      opc_branch: begin
        fmt_dec    = imm_b;
        rs1_en_dec = 1'b1;
        rs2_en_dec = 1'b1;
        case (word.b.funct3)
          f3_beq:  op_dec = alu_beq;
          f3_bne:  op_dec = alu_bne;
          f3_blt:  op_dec = alu_blt;
          f3_bge:  op_dec = alu_bge;
          f3_bltu: op_dec = alu_bltu;
          f3_bgeu: op_dec = alu_bgeu;
          default: legal_dec = 1'b0;  // 010, 011 reserved
        endcase
      end
      opc_load: begin
        op_dec     = alu_load;
        fmt_dec    = imm_i;
        rs1_en_dec = 1'b1;
        rd_wen_dec = 1'b1;
        legal_dec  = (word.i.funct3 inside {f3_byte, f3_half, f3_word, f3_byteu, f3_halfu});
      end
      opc_store: begin
        op_dec     = alu_store;
        fmt_dec    = imm_s;
        rs1_en_dec = 1'b1;
        rs2_en_dec = 1'b1;
        legal_dec  = (word.s.funct3 inside {f3_byte, f3_half, f3_word});  // no unsigned
      end
      opc_op_imm: begin
        fmt_dec    = imm_i;
        rs1_en_dec = 1'b1;
        rd_wen_dec = 1'b1;
        case (word.i.funct3)
          f3_add_sub: op_dec = alu_add;
          f3_slt:     op_dec = alu_slt;
          f3_sltu:    op_dec = alu_sltu;
          f3_xor:     op_dec = alu_xor;
          f3_or:      op_dec = alu_or;
          f3_and:     op_dec = alu_and;
          f3_sll: begin
            op_dec    = alu_sll;
            legal_dec = f7_base_hit;  // shamt upper bits zero
          end
          default: begin
            op_dec    = f7_alt_hit ? alu_sra : alu_srl;
            legal_dec = f7_base_hit | f7_alt_hit;
          end
        endcase
      end
      opc_op: begin
        rs1_en_dec = 1'b1;
        rs2_en_dec = 1'b1;
        rd_wen_dec = 1'b1;
        case (word.r.funct3)
          f3_add_sub: op_dec = f7_alt_hit ? alu_sub : alu_add;
          f3_sll:     op_dec = alu_sll;
          f3_slt:     op_dec = alu_slt;
          f3_sltu:    op_dec = alu_sltu;
          f3_xor:     op_dec = alu_xor;
          f3_or:      op_dec = alu_or;
          f3_and:     op_dec = alu_and;
          default:    op_dec = f7_alt_hit ? alu_sra : alu_srl;
        endcase
        // alternate funct7 only for sub and sra
        legal_dec = f7_base_hit |
                    (f7_alt_hit & (word.r.funct3 inside {f3_add_sub, f3_srl_sra}));
      end
      default: legal_dec = 1'b0;  // unlisted opcode
    endcase
  end

  assign illegal = ~legal_dec | (word.r.opcode[1:0] != 2'b11);

  // ***********************************************************
  // operand requests, illegal words read nothing
  // ***********************************************************
  assign gpr_rd.rs1_addr = word.r.rs1;
  assign gpr_rd.rs2_addr = word.r.rs2;
  assign gpr_rd.rs1_en   = ib_head.valid & rs1_en_dec & ~illegal;
  assign gpr_rd.rs2_en   = ib_head.valid & rs2_en_dec & ~illegal;
  assign imm_fmt         = illegal ? imm_none : fmt_dec;

  always_comb begin
    next_pkt          = '0;
    next_pkt.valid    = 1'b1;
    next_pkt.illegal  = illegal;
    next_pkt.op       = illegal ? alu_add : op_dec;
    next_pkt.rd_wen   = rd_wen_dec & ~illegal;
    next_pkt.rd       = next_pkt.rd_wen ? word.r.rd : '0;  // no target, no rd
    next_pkt.rs1_data = rs1_data;
    next_pkt.rs2_data = rs2_data;
    next_pkt.immed    = immed;
    next_pkt.pc       = ib_head.pc;
  end

  // ***********************************************************
  // packet register and stall
  // ***********************************************************
  assign load   = ib_head.valid & (~dec_pkt.valid | ~exu_stall);  // empty or draining
  assign ib_pop = load;

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_pkt.valid <= 1'b0;
    end else if (load) begin
      dec_pkt <= next_pkt;
    end else if (!exu_stall) begin
      dec_pkt.valid <= 1'b0;  // drained, nothing behind
    end
  end

endmodule

// File: hw/dec_imm_gen.sv
// Immediate extraction and sign extension for RV32I formats; driven by the decode control module
`timescale 1ns/100ps
`include "dec_cfg.svh"

module dec_imm_gen (
  input  dec_isa_pkg::instr_u   instr,
  input  dec_isa_pkg::imm_fmt_e imm_fmt,
  output logic [`DEC_XLEN-1:0]  immed
);

  import dec_isa_pkg::*;

  // ***********************************************************
  // format select, sign always from bit 31
  // ***********************************************************
  always_comb begin
    case (imm_fmt)
      imm_i: begin
        immed = {{(`DEC_XLEN - 12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
      end
      imm_s: begin
        immed = {{(`DEC_XLEN - 12){instr.s.imm_11_5[6]}},
                 instr.s.imm_11_5,
                 instr.s.imm_4_0};
      end
      imm_b: begin  // halfword offset, bit 0 zero
        immed = {{(`DEC_XLEN - 13){instr.b.imm_12}},
                 instr.b.imm_12,
                 instr.b.imm_11,
                 instr.b.imm_10_5,
                 instr.b.imm_4_1,
                 1'b0};
      end
      imm_u: begin  // upper 20, low 12 zero
        immed = {instr.u.imm_31_12, 12'b0};
      end
      imm_j: begin  // jal offset, bit 0 zero
        immed = {{(`DEC_XLEN - 21){instr.j.imm_20}},
                 instr.j.imm_20,
                 instr.j.imm_19_12,
                 instr.j.imm_11,
                 instr.j.imm_10_1,
                 1'b0};
      end
      default: begin
        immed = '0;  // none or unused code
      end
    endcase
  end

endmodule

// File: hw/dec_gpr.sv
// Integer register file with x0 hardwired and writeback forwarding; read by the decode control
`timescale 1ns/100ps
`include "dec_cfg.svh"

module dec_gpr (
  input  logic                  clk,
  input  logic                  reset,
  input  dec_pipe_pkg::gpr_rd_t gpr_rd,
  input  dec_pipe_pkg::wb_pkt_t wb,
  output logic [`DEC_XLEN-1:0]  rs1_data,
  output logic [`DEC_XLEN-1:0]  rs2_data
);

  logic [`DEC_XLEN-1:0] gpr_q [1:`DEC_NUM_GPR-1];  // x0 has no storage

  // ***********************************************************
  // write port
  // ***********************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < `DEC_NUM_GPR; i++) begin
        gpr_q[i] <= '0;
      end
    end else if (wb.wen && (wb.waddr != '0)) begin
      gpr_q[wb.waddr] <= wb.wdata;
    end
  end

  // one read port, same-cycle write wins over the array
  function automatic logic [`DEC_XLEN-1:0] read_port(
    input logic [`DEC_REG_AW-1:0] addr,
    input logic                   en
  );
    logic [`DEC_XLEN-1:0] data;
    data = '0;  // disabled or x0
    if (en && (addr != '0)) begin
      if (wb.wen && (wb.waddr == addr)) begin
        data = wb.wdata;
      end else begin
        data = gpr_q[addr];
      end
    end
    return data;
  endfunction

  always_comb begin
    rs1_data = read_port(gpr_rd.rs1_addr, gpr_rd.rs1_en);
    rs2_data = read_port(gpr_rd.rs2_addr, gpr_rd.rs2_en);
  end

endmodule

// File: hw/dec_top.sv
// Decode stage top level; the testbench instantiates this between its fetch and execute models
`timescale 1ns/100ps
`include "dec_cfg.svh"

module dec_top (
  input  logic                     clk,
  input  logic                     reset,
  input  dec_pipe_pkg::fetch_pkt_t fetch,
  output logic                     ib_ready,
  input  logic                     exu_stall,
  input  dec_pipe_pkg::wb_pkt_t    wb,
  output dec_pipe_pkg::alu_pkt_t   dec_pkt
);

  import dec_isa_pkg::*;
  import dec_pipe_pkg::*;

  fetch_pkt_t           ib_head;     // buffer head
  logic                 ib_pop;
  gpr_rd_t              gpr_rd;
  logic [`DEC_XLEN-1:0] rs1_data;
  logic [`DEC_XLEN-1:0] rs2_data;
  instr_u               head_instr;  // to immediate unit
  imm_fmt_e             imm_fmt;
  logic [`DEC_XLEN-1:0] immed;

  // ***********************************************************
  // stage blocks
  // ***********************************************************
  dec_ib ib_i (.clk, .reset, .fetch, .ib_ready, .ib_pop, .ib_head);

  dec_decode_ctl decode_i (
    .clk, .reset, .ib_head, .ib_pop, .gpr_rd, .rs1_data, .rs2_data,
    .head_instr, .imm_fmt, .immed, .exu_stall, .dec_pkt
  );

  dec_imm_gen imm_i (.instr(head_instr), .imm_fmt, .immed);

  dec_gpr gpr_i (.clk, .reset, .gpr_rd, .wb, .rs1_data, .rs2_data);

endmodule

// File: sim/dec_tb_sva.sv
// Concurrent checks on the decode control module, attached by bind from the testbench file list
`timescale 1ns/100ps

module dec_tb_sva (
  input logic                     clk,
  input logic                     reset,
  input dec_pipe_pkg::fetch_pkt_t ib_head,
  input logic                     ib_pop,
  input logic                     exu_stall,
  input dec_pipe_pkg::alu_pkt_t   dec_pkt
);

  // ************************************************************
  // packet register
  // ************************************************************
  valid_low_after_reset: assert property (
    @(posedge clk) reset |=> !dec_pkt.valid
  ) else $error("packet valid high after a reset cycle");

  stalled_pkt_stable: assert property (
    @(posedge clk) disable iff (reset) (dec_pkt.valid && exu_stall) |=> $stable(dec_pkt)
  ) else $error("stalled packet changed");

  illegal_no_rd_wen: assert property (
    @(posedge clk) disable iff (reset) (dec_pkt.valid && dec_pkt.illegal) |-> !dec_pkt.rd_wen
  ) else $error("illegal packet carries rd_wen");

  // ************************************************************
  // buffer side
  // ************************************************************
  pop_with_head: assert property (
    @(posedge clk) disable iff (reset)
      ib_pop |=> $past(ib_head.valid) && dec_pkt.valid && (dec_pkt.pc == $past(ib_head.pc))
  ) else $error("ib_pop without a valid head reaching the packet register");

endmodule

bind dec_decode_ctl dec_tb_sva sva_i (
  .clk, .reset, .ib_head, .ib_pop, .exu_stall, .dec_pkt
);

// File: sim/dec_tb.sv
// Self-checking testbench for the decode stage; run dec_tb as the simulation top with all.f
`timescale 1ns/100ps
`include "dec_cfg.svh"

module dec_tb;

  import dec_isa_pkg::*;
  import dec_pipe_pkg::*;

  localparam int wait_limit = 200;  // cycles per wait loop

  logic       clk;
  logic       reset;
  fetch_pkt_t fetch;
  logic       ib_ready;
  logic       exu_stall;
  wb_pkt_t    wb;
  alu_pkt_t   dec_pkt;

  logic [`DEC_XLEN-1:0] model_gpr [`DEC_NUM_GPR];  // x0 never written
  alu_pkt_t             exp_q [$];                 // accepted and not yet consumed
  alu_pkt_t             last_pkt;
  logic                 held_prev;
  logic                 fetch_taken;               // set at negedge and read after posedge
  logic                 saw_full;
  int                   stall_mode;                // 0 off, 1 random, 2 held
  logic [`DEC_XLEN-1:0] next_pc;

  dec_top dut_i (.clk, .reset, .fetch, .ib_ready, .exu_stall, .wb, .dec_pkt);

  always #5 clk = ~clk;

  // ************************************************************
  // reporting and compare tasks
  // ************************************************************
  task automatic stop_run();
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_pkt(input alu_pkt_t got, input alu_pkt_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s packet differs", $time, what);
      $display("  got op=%s rd=%0d wen=%b ill=%b rs1=%h rs2=%h imm=%h pc=%h", got.op.name(),
               got.rd, got.rd_wen, got.illegal, got.rs1_data, got.rs2_data, got.immed, got.pc);
      $display("  exp op=%s rd=%0d wen=%b ill=%b rs1=%h rs2=%h imm=%h pc=%h", exp.op.name(),
               exp.rd, exp.rd_wen, exp.illegal, exp.rs1_data, exp.rs2_data, exp.immed, exp.pc);
      stop_run();
    end
  endtask

  task automatic check_ready(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  // ************************************************************
  // reference decode from the RV32I encoding rules
  // ************************************************************
  function automatic alu_pkt_t ref_decode(input logic [31:0] w, input logic [31:0] pc,
                                          input logic [31:0] regs [`DEC_NUM_GPR]);
    alu_pkt_t    p;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        ok;
    logic        use1;
    logic        use2;
    logic        wen;
    alu_op_e     op;
    logic [31:0] imm;
    f3   = w[14:12];
    f7   = w[31:25];
    ok   = 1'b1;
    use1 = 1'b0;
    use2 = 1'b0;
    wen  = 1'b0;
    op   = alu_add;
    imm  = '0;
    case (w[6:0])
      7'b0110111: begin
        op  = alu_lui;
        wen = 1'b1;
        imm = {w[31:12], 12'b0};
      end
      7'b0010111: begin
        op  = alu_auipc;
        wen = 1'b1;
        imm = {w[31:12], 12'b0};
      end
      7'b1101111: begin
        op  = alu_jal;
        wen = 1'b1;
        imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      7'b1100111: begin
        op   = alu_jalr;
        use1 = 1'b1;
        wen  = 1'b1;
        ok   = (f3 == 3'd0);
        imm  = {{20{w[31]}}, w[31:20]};
      end
      7'b1100011: begin
        use1 = 1'b1;
        use2 = 1'b1;
        imm  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        case (f3)
          3'd0: op = alu_beq;
          3'd1: op = alu_bne;
          3'd4: op = alu_blt;
          3'd5: op = alu_bge;
          3'd6: op = alu_bltu;
          3'd7: op = alu_bgeu;
          default: ok = 1'b0;  // 010 and 011 reserved
        endcase
      end
      7'b0000011: begin
        op   = alu_load;
        use1 = 1'b1;
        wen  = 1'b1;
        ok   = (f3 != 3'd3) && (f3 < 3'd6);
        imm  = {{20{w[31]}}, w[31:20]};
      end
      7'b0100011: begin
        op   = alu_store;
        use1 = 1'b1;
        use2 = 1'b1;
        ok   = (f3 < 3'd3);
        imm  = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      7'b0010011: begin
        use1 = 1'b1;
        wen  = 1'b1;
        imm  = {{20{w[31]}}, w[31:20]};
        case (f3)
          3'd0: op = alu_add;
          3'd1: begin
            op = alu_sll;
            ok = (f7 == 7'h00);
          end
          3'd2: op = alu_slt;
          3'd3: op = alu_sltu;
          3'd4: op = alu_xor;
          3'd5: begin
            op = (f7 == 7'h20) ? alu_sra : alu_srl;
            ok = (f7 == 7'h00) || (f7 == 7'h20);
          end
          3'd6: op = alu_or;
          default: op = alu_and;
        endcase
      end
      7'b0110011: begin
        use1 = 1'b1;
        use2 = 1'b1;
        wen  = 1'b1;
        case (f3)
          3'd0: op = (f7 == 7'h20) ? alu_sub : alu_add;
          3'd1: op = alu_sll;
          3'd2: op = alu_slt;
          3'd3: op = alu_sltu;
          3'd4: op = alu_xor;
          3'd5: op = (f7 == 7'h20) ? alu_sra : alu_srl;
          3'd6: op = alu_or;
          default: op = alu_and;
        endcase
        ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
      end
      default: ok = 1'b0;  // includes low bits other than 11
    endcase
    p         = '0;
    p.valid   = 1'b1;
    p.pc      = pc;
    p.illegal = ~ok;
    p.op      = alu_add;
    if (ok) begin
      p.op       = op;
      p.rd_wen   = wen;
      p.rd       = wen ? w[11:7] : 5'd0;
      p.rs1_data = use1 ? regs[w[19:15]] : '0;
      p.rs2_data = use2 ? regs[w[24:20]] : '0;
      p.immed    = imm;
    end
    return p;
  endfunction

  // ************************************************************
  // random instruction words
  // ************************************************************
  function automatic logic [31:0] rand_legal();
    logic [31:0] w;
    logic [2:0]  f3;
    w  = $urandom();
    f3 = w[14:12];
    case ($urandom_range(0, 8))
      0: w[6:0] = 7'b0110111;
      1: w[6:0] = 7'b0010111;
      2: w[6:0] = 7'b1101111;
      3: begin
        w[6:0]   = 7'b1100111;
        w[14:12] = 3'd0;
      end
      4: begin
        w[6:0]   = 7'b1100011;
        f3       = 3'($urandom_range(0, 5));
        w[14:12] = (f3 < 3'd2) ? f3 : f3 + 3'd2;  // skip 010 and 011
      end
      5: begin
        w[6:0]   = 7'b0000011;
        f3       = 3'($urandom_range(0, 4));
        w[14:12] = (f3 < 3'd3) ? f3 : f3 + 3'd1;  // skip 011
      end
      6: begin
        w[6:0]   = 7'b0100011;
        w[14:12] = 3'($urandom_range(0, 2));
      end
      7: begin
        w[6:0] = 7'b0010011;
        if (f3 == 3'd1) w[31:25] = 7'h00;
        else if (f3 == 3'd5) w[31:25] = $urandom_range(0, 1) ? 7'h20 : 7'h00;
      end
      default: begin
        w[6:0]   = 7'b0110011;
        w[31:25] = (((f3 == 3'd0) || (f3 == 3'd5)) && $urandom_range(0, 1)) ? 7'h20 : 7'h00;
      end
    endcase
    return w;
  endfunction

  function automatic logic [31:0] rand_illegal();
    logic [31:0] w;
    alu_pkt_t    p;
    for (int i = 0; i < 100; i++) begin
      w = $urandom();
      p = ref_decode(w, '0, model_gpr);
      if (p.illegal) return w;
    end
    return 32'h0000_0000;  // opcode zero is never legal
  endfunction

  // ************************************************************
  // drive tasks change inputs 1 ns after the rising edge
  // ************************************************************
  task automatic step();
    @(posedge clk);
    #1;
    case (stall_mode)
      0: exu_stall = 1'b0;
      1: exu_stall = 1'($urandom_range(0, 1));
      default: exu_stall = 1'b1;
    endcase
  endtask

  task automatic push_instr(input logic [31:0] w);
    int   tries;
    logic taken;
    fetch.valid = 1'b1;
    fetch.instr = w;
    fetch.pc    = next_pc;
    tries       = 0;
    taken       = 1'b0;
    while (!taken) begin
      step();
      taken = fetch_taken;  // transfer at the edge just passed
      tries++;
      if (!taken && (tries > wait_limit)) begin
        $display("timeout: fetch word at pc %h was never accepted", next_pc);
        stop_run();
      end
    end
    fetch.valid = 1'b0;
    next_pc     = next_pc + 32'd4;
  endtask

  task automatic drain();
    int tries;
    tries      = 0;
    stall_mode = 0;
    while (exp_q.size() != 0) begin
      step();
      tries++;
      if (tries > wait_limit) begin
        $display("timeout: %0d packets never left the decode stage", exp_q.size());
        stop_run();
      end
    end
  endtask

  task automatic write_regs(input int n, input logic hit_x0);
    for (int i = 0; i < n; i++) begin
      step();
      wb.wen   = 1'b1;
      wb.waddr = (hit_x0 && (i == 0)) ? 5'd0 : 5'($urandom_range(0, 31));
      wb.wdata = $urandom();
    end
    step();
    wb.wen = 1'b0;
  endtask

  // ************************************************************
  // monitor samples at the falling edge where all inputs are settled
  // ************************************************************
  always @(negedge clk) begin
    int buf_cnt;
    if (!reset) begin
      buf_cnt = exp_q.size() - int'(dec_pkt.valid);  // entries still in the buffer
      if (buf_cnt < 2) begin
        check_ready(ib_ready, 1'b1, "ib_ready with buffer space");
      end else if (dec_pkt.valid && exu_stall) begin
        check_ready(ib_ready, 1'b0, "ib_ready behind stalled packet");
        saw_full = 1'b1;
      end
      if (held_prev) check_pkt(dec_pkt, last_pkt, "stalled");
      if (dec_pkt.valid && !exu_stall) begin
        if (exp_q.size() == 0) begin
          $display("unexpected packet at %0t with nothing fetched", $time);
          stop_run();
        end
        check_pkt(dec_pkt, exp_q.pop_front(), "consumed");
      end
      held_prev   = dec_pkt.valid & exu_stall;
      last_pkt    = dec_pkt;
      fetch_taken = fetch.valid & ib_ready;
      if (fetch_taken) begin
        exp_q.push_back(ref_decode(fetch.instr, fetch.pc, model_gpr));
      end
      if (wb.wen && (wb.waddr != 5'd0)) model_gpr[wb.waddr] = wb.wdata;
    end
  end

  // ************************************************************
  // test sequence
  // ************************************************************
  initial begin
    void'($urandom(32'hcc7a));
    clk         = 1'b0;
    reset       = 1'b1;
    fetch       = '0;
    wb          = '0;
    exu_stall   = 1'b0;
    held_prev   = 1'b0;
    fetch_taken = 1'b0;
    saw_full    = 1'b0;
    stall_mode  = 0;
    next_pc     = 32'h8000_0000;
    for (int i = 0; i < `DEC_NUM_GPR; i++) model_gpr[i] = '0;

    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    check_ready(dec_pkt.valid, 1'b0, "dec_pkt.valid after reset");
    check_ready(ib_ready, 1'b1, "ib_ready after reset");

    write_regs(40, 1'b1);                         // fill registers with x0 written first
    push_instr(32'h0000_02b3);                    // add x5, x0, x0
    repeat (60) push_instr(rand_legal());
    drain();

    write_regs(12, 1'b1);
    push_instr(32'h0000_02b3);
    repeat (20) push_instr(rand_illegal());
    drain();

    stall_mode = 2;                               // hold execute so the buffer fills
    repeat (3) push_instr(rand_legal());
    repeat (3) step();
    drain();

    stall_mode = 1;
    for (int i = 0; i < 80; i++) begin
      push_instr(($urandom_range(0, 4) == 0) ? rand_illegal() : rand_legal());
    end
    drain();
    repeat (3) step();

    if (saw_full) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("ib_ready was never seen low with two words behind a stalled packet");
      $display("** FAIL **");
      $fatal(1, "end of run check failed");
    end
  end

endmodule

// File: all.f
+incdir+hw
hw/dec_isa_pkg.sv
hw/dec_pipe_pkg.sv
hw/dec_ib.sv
hw/dec_decode_ctl.sv
hw/dec_imm_gen.sv
hw/dec_gpr.sv
hw/dec_top.sv
sim/dec_tb_sva.sv
sim/dec_tb.sv

// File: Bender.yml
package:
  name: dec_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/dec_isa_pkg.sv
      - hw/dec_pipe_pkg.sv
      - hw/dec_ib.sv
      - hw/dec_decode_ctl.sv
      - hw/dec_imm_gen.sv
      - hw/dec_gpr.sv
      - hw/dec_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - sim/dec_tb_sva.sv
      - sim/dec_tb.sv
